// ==== common/pic_pkg.sv ====
// Shared definitions for the 8259-style interrupt controller
// Vector widths, reset values, FSM encodings and a level encoder

package pic_pkg;

    localparam int NUM_IRQ        = 8;
    localparam int POLL_VALID_BIT = 7;

    // One bit per request line
    typedef logic [NUM_IRQ-1:0] irq_vec_t;
    typedef logic [2:0]         irq_level_t;
    // T7-T3 of the vector byte
    typedef logic [4:0]         vector_base_t;
    typedef logic [7:0]         bus_data_t;

    localparam irq_vec_t   IMR_RESET    = '1;
    localparam irq_level_t ROTATE_RESET = 3'd7;

    typedef enum logic [1:0] {
        INIT_READY,
        INIT_ICW2,
        INIT_ICW4
    } init_state_t;

    typedef enum logic [1:0] {
        ACK_IDLE,
        ACK_FIRST,
        ACK_SECOND,
        ACK_POLL
    } ack_state_t;

    // Level number of a one-hot request vector
    function automatic irq_level_t level_of(input irq_vec_t onehot);
        irq_level_t level;
        level = '0;
        for (int i = 0; i < NUM_IRQ; i++) begin
            if (onehot[i]) begin
                level = irq_level_t'(i);
            end
        end
        return level;
    endfunction

endpackage

// ==== hw/priority/pic_request_latch.sv ====
// Interrupt request register
// Edge or level capture of the eight request lines

`timescale 1ns/1ps

module pic_request_latch (
    input  logic               clock,
    input  logic               reset,
    input  pic_pkg::irq_vec_t  irq,
    input  logic               level_triggered,
    input  logic               clear_all,
    input  pic_pkg::irq_vec_t  clear_request,
    output pic_pkg::irq_vec_t  irr
);

    pic_pkg::irq_vec_t irq_prev;
    pic_pkg::irq_vec_t irq_rise;

    always_ff @(posedge clock) begin
        if (reset) begin
            irq_prev <= '0;
        end else begin
            irq_prev <= irq;
        end
    end

    assign irq_rise = irq & ~irq_prev;

    always_ff @(posedge clock) begin
        if (reset || clear_all) begin
            irr <= '0;
        end else if (level_triggered) begin
            // Level mode, bit follows the line
            irr <= irq & ~clear_request;
        end else begin
            irr <= (irr | irq_rise) & ~clear_request;
        end
    end

endmodule

// ==== hw/priority/pic_priority_resolver.sv ====
// In-service register and rotating priority resolver
// Highest priority level is priority_rotate + 1, wrapping

`timescale 1ns/1ps

module pic_priority_resolver (
    input  logic                 clock,
    input  logic                 reset,
    input  pic_pkg::irq_vec_t    irr,
    input  pic_pkg::irq_vec_t    interrupt_mask,
    input  pic_pkg::irq_level_t  priority_rotate,
    input  logic                 latch_in_service,
    input  pic_pkg::irq_vec_t    acknowledged,
    input  pic_pkg::irq_vec_t    end_of_interrupt,
    input  logic                 auto_clear,
    output pic_pkg::irq_vec_t    pending,
    output pic_pkg::irq_vec_t    isr,
    output pic_pkg::irq_vec_t    highest_in_service,
    output pic_pkg::irq_vec_t    clear_request
);

    pic_pkg::irq_vec_t requests;

    assign requests = irr & ~interrupt_mask;

    // Walk levels from highest priority down
    always_comb begin
        pic_pkg::irq_level_t level;
        logic                isr_found;
        logic                req_found;
        pending            = '0;
        highest_in_service = '0;
        isr_found          = 1'b0;
        req_found          = 1'b0;
        for (int i = 0; i < pic_pkg::NUM_IRQ; i++) begin
            level = priority_rotate + pic_pkg::irq_level_t'(i + 1);
            if (isr[level] && !isr_found) begin
                highest_in_service[level] = 1'b1;
                isr_found                 = 1'b1;
            end
            // Must beat every in-service level strictly
            if (requests[level] && !isr_found && !req_found) begin
                pending[level] = 1'b1;
                req_found      = 1'b1;
            end
        end
    end

    assign clear_request = latch_in_service ? pending : '0;

    always_ff @(posedge clock) begin
        if (reset) begin
            isr <= '0;
        end else begin
            isr <= (isr | clear_request) & ~end_of_interrupt &
                   ~(auto_clear ? acknowledged : '0);
        end
    end

endmodule

// ==== hw/control/pic_command_regs.sv ====
// Command word registers
// Init sequence ICW1 -> ICW2 -> (ICW4), mask, read select,
// rotation and OCW2 end-of-interrupt decode

`timescale 1ns/1ps

module pic_command_regs (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   write_icw1,
    input  logic                   write_icw2_4,
    input  logic                   write_ocw1,
    input  logic                   write_ocw2,
    input  logic                   write_ocw3,
    input  pic_pkg::bus_data_t     wdata,
    input  pic_pkg::irq_vec_t      highest_in_service,
    output logic                   init_pending,
    output logic                   level_triggered,
    output pic_pkg::vector_base_t  vector_base,
    output logic                   auto_eoi,
    output pic_pkg::irq_vec_t      interrupt_mask,
    output pic_pkg::irq_level_t    priority_rotate,
    output pic_pkg::irq_vec_t      end_of_interrupt,
    output logic                   read_isr,
    output logic                   poll_command,
    output logic                   clear_all
);

    pic_pkg::init_state_t init_state;
    logic                 icw4_needed;
    logic                 ocw2_valid;
    logic                 ocw3_valid;
    logic [2:0]           ocw2_cmd;

    assign init_pending = (init_state != pic_pkg::INIT_READY);
    // OCW2/OCW3 ignored until init completes
    assign ocw2_valid   = write_ocw2 & ~init_pending;
    assign ocw3_valid   = write_ocw3 & ~init_pending;
    assign ocw2_cmd     = wdata[7:5];
    assign poll_command = ocw3_valid & wdata[2];
    assign clear_all    = write_icw1;

    always_ff @(posedge clock) begin
        if (reset) begin
            init_state <= pic_pkg::INIT_READY;
        end else if (write_icw1) begin
            init_state <= pic_pkg::INIT_ICW2;
        end else if (write_icw2_4) begin
            case (init_state)
                pic_pkg::INIT_ICW2:
                    init_state <= icw4_needed ? pic_pkg::INIT_ICW4 : pic_pkg::INIT_READY;
                default:
                    init_state <= pic_pkg::INIT_READY;
            endcase
        end
    end

    // ICW1 and ICW4 fields
    always_ff @(posedge clock) begin
        if (reset) begin
            icw4_needed     <= 1'b0;
            level_triggered <= 1'b0;
            auto_eoi        <= 1'b0;
        end else if (write_icw1) begin
            icw4_needed     <= wdata[0];
            level_triggered <= wdata[3];
            auto_eoi        <= 1'b0;
        end else if (write_icw2_4 && init_state == pic_pkg::INIT_ICW4) begin
            auto_eoi        <= wdata[1];
        end
    end

    always_ff @(posedge clock) begin
        if (write_icw2_4 && init_state == pic_pkg::INIT_ICW2) begin
            vector_base <= wdata[7:3];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            interrupt_mask <= pic_pkg::IMR_RESET;
        end else if (write_ocw1) begin
            interrupt_mask <= wdata;
        end
    end

    // RR/RIS select, IRR again after init
    always_ff @(posedge clock) begin
        if (reset || write_icw1) begin
            read_isr <= 1'b0;
        end else if (ocw3_valid && wdata[1]) begin
            read_isr <= wdata[0];
        end
    end

    always_ff @(posedge clock) begin
        if (reset || write_icw1) begin
            priority_rotate <= pic_pkg::ROTATE_RESET;
        end else if (ocw2_valid) begin
            case (ocw2_cmd)
                3'b101: begin
                    if (|highest_in_service) begin
                        priority_rotate <= pic_pkg::level_of(highest_in_service);
                    end
                end
                3'b110, 3'b111: priority_rotate <= wdata[2:0];
                default: ;
            endcase
        end
    end

    // One-cycle ISR clear mask
    always_comb begin
        end_of_interrupt = '0;
        if (ocw2_valid) begin
            case (ocw2_cmd)
                3'b001, 3'b101: end_of_interrupt = highest_in_service;
                3'b011, 3'b111: end_of_interrupt = pic_pkg::irq_vec_t'(1) << wdata[2:0];
                default:        end_of_interrupt = '0;
            endcase
        end
    end

endmodule

// ==== hw/control/pic_ack_control.sv ====
// Acknowledge and poll sequencing
// Two-pulse inta_n handshake, vector byte, poll byte and int_out

`timescale 1ns/1ps

module pic_ack_control (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   inta_n,
    input  pic_pkg::irq_vec_t      pending,
    input  logic                   poll_command,
    input  logic                   read_poll,
    input  pic_pkg::vector_base_t  vector_base,
    input  logic                   auto_eoi,
    output logic                   int_out,
    output pic_pkg::bus_data_t     ack_data,
    output logic                   ack_data_valid,
    output logic                   latch_in_service,
    output pic_pkg::irq_vec_t      acknowledged,
    output logic                   auto_clear,
    output logic                   poll_pending,
    output pic_pkg::bus_data_t     poll_data
);

    pic_pkg::ack_state_t ack_state;
    pic_pkg::ack_state_t next_state;
    pic_pkg::irq_level_t ack_level;
    logic                inta_n_prev;
    logic                inta_fall;
    logic                inta_rise;
    logic                end_of_sequence;

    always_ff @(posedge clock) begin
        if (reset) begin
            inta_n_prev <= 1'b1;
        end else begin
            inta_n_prev <= inta_n;
        end
    end

    assign inta_fall = inta_n_prev & ~inta_n;
    assign inta_rise = ~inta_n_prev & inta_n;

    always_comb begin
        next_state = ack_state;
        case (ack_state)
            pic_pkg::ACK_IDLE: begin
                if (poll_command) begin
                    next_state = pic_pkg::ACK_POLL;
                end else if (inta_fall && |pending) begin
                    next_state = pic_pkg::ACK_FIRST;
                end
            end
            pic_pkg::ACK_FIRST:  if (inta_rise) next_state = pic_pkg::ACK_SECOND;
            pic_pkg::ACK_SECOND: if (inta_rise) next_state = pic_pkg::ACK_IDLE;
            pic_pkg::ACK_POLL:   if (read_poll) next_state = pic_pkg::ACK_IDLE;
            default:             next_state = pic_pkg::ACK_IDLE;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            ack_state <= pic_pkg::ACK_IDLE;
        end else begin
            ack_state <= next_state;
        end
    end

    // ISR latch on entry to either sequence
    assign latch_in_service = (ack_state == pic_pkg::ACK_IDLE) &&
                              (next_state != pic_pkg::ACK_IDLE);
    assign end_of_sequence  = (ack_state == pic_pkg::ACK_SECOND && inta_rise) ||
                              (ack_state == pic_pkg::ACK_POLL && read_poll);
    assign auto_clear       = auto_eoi && ack_state == pic_pkg::ACK_SECOND && inta_rise;

    always_ff @(posedge clock) begin
        if (latch_in_service) begin
            acknowledged <= pending;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            int_out <= 1'b0;
        end else if (|pending) begin
            int_out <= 1'b1;
        end else if (end_of_sequence) begin
            int_out <= 1'b0;
        end
    end

    assign ack_level      = pic_pkg::level_of(acknowledged);
    assign poll_pending   = (ack_state == pic_pkg::ACK_POLL);
    assign ack_data_valid = (ack_state == pic_pkg::ACK_SECOND) && !inta_n;
    assign ack_data       = ack_data_valid ? {vector_base, ack_level} : '0;

    // Zero when nothing was pending at the poll command
    always_comb begin
        poll_data = '0;
        if (|acknowledged) begin
            poll_data[2:0]                     = ack_level;
            poll_data[pic_pkg::POLL_VALID_BIT] = 1'b1;
        end
    end

endmodule

// ==== hw/pic_bus_decoder.sv ====
// APB register decode
// paddr plays the A0 role; writes become command-word strobes,
// reads select poll byte, IRR, ISR or IMR

`timescale 1ns/1ps

module pic_bus_decoder (
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic                paddr,
    input  pic_pkg::bus_data_t  pwdata,
    input  logic                init_pending,
    input  logic                read_isr,
    input  pic_pkg::irq_vec_t   irr,
    input  pic_pkg::irq_vec_t   isr,
    input  pic_pkg::irq_vec_t   interrupt_mask,
    input  logic                poll_pending,
    input  pic_pkg::bus_data_t  poll_data,
    output pic_pkg::bus_data_t  prdata,
    output logic                write_icw1,
    output logic                write_icw2_4,
    output logic                write_ocw1,
    output logic                write_ocw2,
    output logic                write_ocw3,
    output pic_pkg::bus_data_t  wdata,
    output logic                read_poll
);

    logic write_access;
    logic read_access;

    // Zero-wait slave, access phase is the only cycle that counts
    assign write_access = psel & penable & pwrite;
    assign read_access  = psel & penable & ~pwrite;

    assign write_icw1   = write_access & ~paddr & pwdata[4];
    assign write_ocw2   = write_access & ~paddr & ~pwdata[4] & ~pwdata[3];
    assign write_ocw3   = write_access & ~paddr & ~pwdata[4] & pwdata[3];
    assign write_icw2_4 = write_access & paddr & init_pending;
    assign write_ocw1   = write_access & paddr & ~init_pending;
    assign wdata        = pwdata;

    // Address-0 read while a poll is open closes the poll
    assign read_poll = read_access & ~paddr & poll_pending;

    always_comb begin
        if (paddr) begin
            prdata = interrupt_mask;
        end else if (poll_pending) begin
            prdata = poll_data;
        end else if (read_isr) begin
            prdata = isr;
        end else begin
            prdata = irr;
        end
    end

endmodule

// ==== hw/pic_top.sv ====
// 8259-style interrupt controller, single chip, 8086 mode
// APB register access, eight request lines, two-pulse acknowledge

`timescale 1ns/1ps

module pic_top (
    input  logic                clock,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic                paddr,
    input  pic_pkg::bus_data_t  pwdata,
    output pic_pkg::bus_data_t  prdata,
    input  pic_pkg::irq_vec_t   irq,
    input  logic                inta_n,
    output logic                int_out,
    output pic_pkg::bus_data_t  ack_data,
    output logic                ack_data_valid
);

    logic                   write_icw1;
    logic                   write_icw2_4;
    logic                   write_ocw1;
    logic                   write_ocw2;
    logic                   write_ocw3;
    pic_pkg::bus_data_t     wdata;
    logic                   read_poll;
    logic                   init_pending;
    logic                   level_triggered;
    pic_pkg::vector_base_t  vector_base;
    logic                   auto_eoi;
    pic_pkg::irq_vec_t      interrupt_mask;
    pic_pkg::irq_level_t    priority_rotate;
    pic_pkg::irq_vec_t      end_of_interrupt;
    logic                   read_isr;
    logic                   poll_command;
    logic                   clear_all;
    pic_pkg::irq_vec_t      irr;
    pic_pkg::irq_vec_t      isr;
    pic_pkg::irq_vec_t      pending;
    pic_pkg::irq_vec_t      highest_in_service;
    pic_pkg::irq_vec_t      clear_request;
    pic_pkg::irq_vec_t      acknowledged;
    logic                   latch_in_service;
    logic                   auto_clear;
    logic                   poll_pending;
    pic_pkg::bus_data_t     poll_data;

    pic_bus_decoder pic_bus_decoder_inst (
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .init_pending   (init_pending),
        .read_isr       (read_isr),
        .irr            (irr),
        .isr            (isr),
        .interrupt_mask (interrupt_mask),
        .poll_pending   (poll_pending),
        .poll_data      (poll_data),
        .prdata         (prdata),
        .write_icw1     (write_icw1),
        .write_icw2_4   (write_icw2_4),
        .write_ocw1     (write_ocw1),
        .write_ocw2     (write_ocw2),
        .write_ocw3     (write_ocw3),
        .wdata          (wdata),
        .read_poll      (read_poll)
    );

    pic_command_regs pic_command_regs_inst (
        .clock              (clock),
        .reset              (reset),
        .write_icw1         (write_icw1),
        .write_icw2_4       (write_icw2_4),
        .write_ocw1         (write_ocw1),
        .write_ocw2         (write_ocw2),
        .write_ocw3         (write_ocw3),
        .wdata              (wdata),
        .highest_in_service (highest_in_service),
        .init_pending       (init_pending),
        .level_triggered    (level_triggered),
        .vector_base        (vector_base),
        .auto_eoi           (auto_eoi),
        .interrupt_mask     (interrupt_mask),
        .priority_rotate    (priority_rotate),
        .end_of_interrupt   (end_of_interrupt),
        .read_isr           (read_isr),
        .poll_command       (poll_command),
        .clear_all          (clear_all)
    );

    pic_ack_control pic_ack_control_inst (
        .clock            (clock),
        .reset            (reset),
        .inta_n           (inta_n),
        .pending          (pending),
        .poll_command     (poll_command),
        .read_poll        (read_poll),
        .vector_base      (vector_base),
        .auto_eoi         (auto_eoi),
        .int_out          (int_out),
        .ack_data         (ack_data),
        .ack_data_valid   (ack_data_valid),
        .latch_in_service (latch_in_service),
        .acknowledged     (acknowledged),
        .auto_clear       (auto_clear),
        .poll_pending     (poll_pending),
        .poll_data        (poll_data)
    );

    pic_request_latch pic_request_latch_inst (
        .clock           (clock),
        .reset           (reset),
        .irq             (irq),
        .level_triggered (level_triggered),
        .clear_all       (clear_all),
        .clear_request   (clear_request),
        .irr             (irr)
    );

    pic_priority_resolver pic_priority_resolver_inst (
        .clock              (clock),
        .reset              (reset),
        .irr                (irr),
        .interrupt_mask     (interrupt_mask),
        .priority_rotate    (priority_rotate),
        .latch_in_service   (latch_in_service),
        .acknowledged       (acknowledged),
        .end_of_interrupt   (end_of_interrupt),
        .auto_clear         (auto_clear),
        .pending            (pending),
        .isr                (isr),
        .highest_in_service (highest_in_service),
        .clear_request      (clear_request)
    );

endmodule

// ==== testbench/tb_pic.sv ====
// Testbench for the 8259-style interrupt controller
// Random levels from an LFSR are checked against a priority model

`timescale 1ns/1ps

module tb_pic;

    localparam int TIMEOUT = 100;

    logic       clock;
    logic       reset;
    logic       psel;
    logic       penable;
    logic       pwrite;
    logic       paddr;
    logic [7:0] pwdata;
    logic [7:0] prdata;
    logic [7:0] irq;
    logic       inta_n;
    logic       int_out;
    logic [7:0] ack_data;
    logic       ack_data_valid;

    logic [15:0] lfsr_state;
    int          errors;
    int          checks;

    // Reference model state
    logic [7:0] model_imr;
    logic [7:0] model_irr;
    logic [7:0] model_isr;
    logic [2:0] model_rotate;
    logic [4:0] model_base;
    logic       model_auto_eoi;

    pic_top pic_top_inst (
        .clock          (clock),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .irq            (irq),
        .inta_n         (inta_n),
        .int_out        (int_out),
        .ack_data       (ack_data),
        .ack_data_valid (ack_data_valid)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // x^16 + x^15 + x^13 + x^4 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[14] ^ state[12] ^ state[3];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [7:0] random_bits(input int count);
        logic [7:0] value;
        value = 8'd0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[6:0], lfsr_state[0]};
        end
        return value;
    endfunction

    function automatic logic [2:0] random_level();
        logic [7:0] value;
        value = random_bits(3);
        return value[2:0];
    endfunction

    // Highest eligible request as {found, level}
    function automatic logic [3:0] model_winner();
        logic [2:0] level;
        logic       blocked;
        logic [3:0] result;
        result  = 4'd0;
        blocked = 1'b0;
        for (int i = 1; i <= 8; i++) begin
            level = model_rotate + 3'(i);
            if (!blocked && !result[3]) begin
                if (model_isr[level]) begin
                    blocked = 1'b1;
                end else if (model_irr[level] && !model_imr[level]) begin
                    result = {1'b1, level};
                end
            end
        end
        return result;
    endfunction

    task automatic step_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic check_value(input string name, input logic [7:0] expected,
                               input logic [7:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error %s: expected %02h, actual %02h", name, expected, actual);
        end
    endtask

    task automatic apb_write(input logic addr, input logic [7:0] data);
        step_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        step_cycle();
        penable = 1'b1;
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic addr, output logic [7:0] data);
        step_cycle();
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        step_cycle();
        penable = 1'b1;
        @(negedge clock);
        data = prdata;
        step_cycle();
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic read_check(input logic addr, input logic [7:0] expected,
                              input string name);
        logic [7:0] data;
        apb_read(addr, data);
        check_value(name, expected, data);
    endtask

    task automatic wait_int_out(input logic value, input string name);
        int cycles;
        cycles = 0;
        @(negedge clock);
        while (int_out !== value && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (int_out !== value) begin
            errors++;
            $display("Timeout: int_out never became %0b in %s", value, name);
        end
    endtask

    // Edge mode pulse lasting one cycle
    task automatic pulse_irq(input logic [7:0] lines);
        step_cycle();
        irq = lines;
        step_cycle();
        irq       = 8'd0;
        model_irr = model_irr | lines;
    endtask

    task automatic init_controller(input logic auto_eoi_on);
        model_base = 5'(random_bits(5));
        apb_write(1'b0, 8'h11);
        apb_write(1'b1, {model_base, 3'b000});
        apb_write(1'b1, {6'd0, auto_eoi_on, 1'b1});
        model_irr      = 8'd0;
        model_rotate   = 3'd7;
        model_auto_eoi = auto_eoi_on;
    endtask

    task automatic set_mask(input logic [7:0] mask);
        apb_write(1'b1, mask);
        model_imr = mask;
    endtask

    task automatic specific_eoi(input logic [2:0] level);
        apb_write(1'b0, {3'b011, 2'b00, level});
        model_isr[level] = 1'b0;
    endtask

    task automatic set_priority(input logic [2:0] level);
        apb_write(1'b0, {3'b110, 2'b00, level});
        model_rotate = level;
    endtask

    // Two inta_n pulses with the vector checked during the second
    task automatic acknowledge(input string name, output logic [2:0] acked_level);
        logic [3:0] winner;
        int         cycles;
        winner      = model_winner();
        acked_level = winner[2:0];
        wait_int_out(1'b1, name);
        step_cycle();
        inta_n = 1'b0;
        repeat (2) step_cycle();
        check_value({name, " valid in first pulse"}, 8'h00, {7'd0, ack_data_valid});
        inta_n = 1'b1;
        repeat (2) step_cycle();
        inta_n = 1'b0;
        cycles = 0;
        @(negedge clock);
        while (!ack_data_valid && cycles < TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (ack_data_valid) begin
            check_value({name, " vector"}, {model_base, winner[2:0]}, ack_data);
        end else begin
            errors++;
            $display("Timeout: ack_data_valid never rose in %s", name);
        end
        step_cycle();
        inta_n = 1'b1;
        step_cycle();
        check_value({name, " valid after pulses"}, 8'h00, {7'd0, ack_data_valid});
        if (winner[3]) begin
            model_irr[winner[2:0]] = 1'b0;
            model_isr[winner[2:0]] = !model_auto_eoi;
        end
    endtask

    task automatic poll_and_check(input string name);
        logic [3:0] winner;
        logic [7:0] expected;
        winner   = model_winner();
        expected = winner[3] ? {1'b1, 4'd0, winner[2:0]} : 8'h00;
        apb_write(1'b0, 8'h0C);
        read_check(1'b0, expected, name);
        if (winner[3]) begin
            model_irr[winner[2:0]] = 1'b0;
            model_isr[winner[2:0]] = 1'b1;
        end
    endtask

    initial begin
        logic [7:0] mask;
        logic [7:0] lines;
        logic [2:0] level_a;
        logic [2:0] level_b;
        logic [2:0] level_c;
        logic [2:0] acked;
        logic       seen;
        reset          = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = 1'b0;
        pwdata         = 8'd0;
        irq            = 8'd0;
        inta_n         = 1'b1;
        lfsr_state     = 16'd16648;
        errors         = 0;
        checks         = 0;
        model_imr      = 8'hFF;
        model_irr      = 8'd0;
        model_isr      = 8'd0;
        model_rotate   = 3'd7;
        model_base     = 5'd0;
        model_auto_eoi = 1'b0;
        repeat (16) step_cycle();
        reset = 1'b0;

        // Init sequence and mask readback
        read_check(1'b1, pic_pkg::IMR_RESET, "imr after reset");
        init_controller(1'b0);
        mask = random_bits(8);
        set_mask(mask);
        read_check(1'b1, mask, "imr readback");

        // Single request
        level_a = random_level();
        if (model_imr[level_a]) begin
            set_mask(model_imr & ~(8'h01 << level_a));
        end
        pulse_irq(8'h01 << level_a);
        read_check(1'b0, model_irr, "irr after edge");
        acknowledge("single request", acked);
        wait_int_out(1'b0, "single request end");
        specific_eoi(acked);

        // Two requests at once with a third line masked
        level_a = random_level();
        level_b = random_level();
        if (level_b == level_a) begin
            level_b = level_a + 3'd1;
        end
        level_c = random_level();
        while (level_c == level_a || level_c == level_b) begin
            level_c = level_c + 3'd1;
        end
        set_mask(~((8'h01 << level_a) | (8'h01 << level_b)));
        pulse_irq((8'h01 << level_a) | (8'h01 << level_b) | (8'h01 << level_c));
        acknowledge("priority winner", acked);
        wait_int_out(1'b0, "priority winner end");
        specific_eoi(acked);
        acknowledge("priority loser", acked);
        wait_int_out(1'b0, "priority loser end");
        specific_eoi(acked);
        seen = 1'b0;
        repeat (10) begin
            @(negedge clock);
            seen = seen | int_out;
        end
        check_value("masked level int_out", 8'h00, {7'd0, seen});

        // ISR readback then auto-EOI
        level_a = random_level();
        set_mask(~(8'h01 << level_a));
        pulse_irq(8'h01 << level_a);
        acknowledge("isr request", acked);
        apb_write(1'b0, 8'h0B);
        read_check(1'b0, model_isr, "isr after acknowledge");
        specific_eoi(acked);
        read_check(1'b0, model_isr, "isr after eoi");
        apb_write(1'b0, 8'h0A);
        init_controller(1'b1);
        pulse_irq(8'h01 << level_a);
        acknowledge("auto eoi request", acked);
        apb_write(1'b0, 8'h0B);
        read_check(1'b0, model_isr, "isr with auto eoi");
        apb_write(1'b0, 8'h0A);

        // Poll
        level_a = random_level();
        set_mask(~(8'h01 << level_a));
        pulse_irq(8'h01 << level_a);
        wait_int_out(1'b1, "poll request");
        poll_and_check("poll byte");
        wait_int_out(1'b0, "poll end");
        specific_eoi(level_a);
        poll_and_check("poll empty");

        // Set priority moves the winner
        for (int round = 0; round < 4; round++) begin
            level_a = random_level();
            level_b = random_level();
            if (level_b == level_a) begin
                level_b = level_a + 3'd1;
            end
            lines = (8'h01 << level_a) | (8'h01 << level_b);
            set_priority(random_level());
            set_mask(~lines);
            pulse_irq(lines);
            acknowledge("rotated winner", acked);
            acknowledge("rotated other", acked);
            wait_int_out(1'b0, "rotated end");
        end

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/pic_pkg.sv
hw/priority/pic_request_latch.sv
hw/priority/pic_priority_resolver.sv
hw/control/pic_command_regs.sv
hw/control/pic_ack_control.sv
hw/pic_bus_decoder.sv
hw/pic_top.sv
testbench/tb_pic.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the interrupt controller testbench with Verilator
verilator --binary --top-module tb_pic -f compile.f -o tb_pic_sim > build.log 2>&1 ||
    { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_pic_sim > sim.log 2>&1
cat sim.log
grep -qF "** FAIL **" sim.log && { echo "Simulation failed"; exit 1; }
grep -qF "** PASS **" sim.log || { echo "Simulation gave no result"; exit 1; }
echo "Simulation passed"
